/* hdl/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// Datapath sizing for the decode/execute/result pipeline

// Data words, addresses and the PC all share this width
`define DATA_W 32

// Index into the register file
`define REG_ADDR_W 5

// Architectural registers, register 0 reads as zero
`define NUM_REGS 32

// Fixed-length MIPS-style encoding
`define INSTR_W 32

// Field positions inside an instruction word are fixed by the ISA
// and are sliced directly in the decode stage:
//   [31:26] opcode
//   [25:21] rs
//   [20:16] rt
//   [15:11] rd
//   [15:0]  immediate
//   [25:0]  jump index
//   [5:0]   function code

`endif

/* hdl/pipe_pkg.sv */
`include "cpu_config.svh"

package pipe_pkg;

    // One data word, also used for addresses and PC
    typedef logic [`DATA_W-1:0] word_t;

    // Register file index
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Operation selected for the single-cycle ALU
    typedef enum logic [2:0] {
        ALU_ADD    = 3'd0,
        ALU_SUB    = 3'd1,
        ALU_AND    = 3'd2,
        ALU_OR     = 3'd3,
        ALU_SLT    = 3'd4, // Signed less-than, result 0 or 1
        ALU_MUL    = 3'd5, // Low half of product
        ALU_PASS_B = 3'd6  // Second operand straight through
    } alu_op_t;

endpackage

/* hdl/isa_pkg.sv */
package isa_pkg;

    // Primary opcode, instruction bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00, // Function code selects operation
        OP_J     = 6'h02, // Absolute jump inside 256 MB region
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08, // Sign-extended immediate
        OP_ORI   = 6'h0d, // Zero-extended immediate
        OP_LDW   = 6'h23,
        OP_LDB   = 6'h24, // Byte load, zero-extended
        OP_STB   = 6'h28,
        OP_STW   = 6'h2b
    } opcode_t;

    // R-type function code, bits 5:0
    typedef enum logic [5:0] {
        FN_MUL = 6'h18, // Low 32 bits of product
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a  // Signed compare
    } funct_t;

    // Raw immediate, bits 15:0
    typedef logic [15:0] imm16_t;

    // Word index of a jump, bits 25:0
    typedef logic [25:0] jump_index_t;

endpackage

/* hdl/stage_if.sv */
// Decode to execute bundle, qualified by ex_valid for one cycle
interface decode_exec_if import pipe_pkg::*; ();
    logic      ex_valid;
    word_t     pc;
    word_t     operand_a;  // rs data
    word_t     operand_b;  // rt data
    word_t     imm;        // Already extended
    reg_addr_t dest_reg;
    alu_op_t   alu_op;
    logic      alu_src;    // 1 selects imm over operand_b
    logic      reg_write;
    logic      mem_to_reg;
    logic      mem_write;
    logic      mem_read;
    logic      byte_word;  // 1 word, 0 byte
    logic      branch;

    modport source (output ex_valid, pc, operand_a, operand_b, imm, dest_reg, alu_op,
                    alu_src, reg_write, mem_to_reg, mem_write, mem_read, byte_word, branch);
    modport sink   (input ex_valid, pc, operand_a, operand_b, imm, dest_reg, alu_op,
                    alu_src, reg_write, mem_to_reg, mem_write, mem_read, byte_word, branch);
endinterface

// Execute to result bundle
interface exec_result_if import pipe_pkg::*; ();
    logic       wb_pending;  // Register write due this cycle
    reg_addr_t  dest_reg;
    word_t      alu_result;
    logic       mem_to_reg;  // Take load data instead of ALU result
    logic       byte_word;   // 1 word, 0 byte
    logic [1:0] load_offset; // Byte lane of the load address

    modport source (output wb_pending, dest_reg, alu_result, mem_to_reg, byte_word,
                    load_offset);
    modport sink   (input wb_pending, dest_reg, alu_result, mem_to_reg, byte_word,
                    load_offset);
endinterface

/* hdl/control_unit.sv */
module control_unit import isa_pkg::*, pipe_pkg::*; (
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,      // Bubble request, also covers no valid instruction
    input  opcode_t opcode,
    input  funct_t  funct,
    output logic    reg_write,
    output logic    mem_to_reg,
    output logic    mem_write,
    output logic    mem_read,
    output logic    byte_word,  // 1 word, 0 byte
    output logic    branch,
    output logic    alu_src,
    output alu_op_t alu_op
);

    // Outputs are flops, so this is the decode register for control
    always_ff @(posedge clk) begin
        // Bubble unless a known opcode overrides below
        reg_write  <= 1'b0;
        mem_to_reg <= 1'b0;
        mem_write  <= 1'b0;
        mem_read   <= 1'b0;
        byte_word  <= 1'b0;
        branch     <= 1'b0;
        alu_src    <= 1'b0;
        alu_op     <= ALU_ADD;
        if (!(reset || stall)) begin
            case (opcode)
                OP_RTYPE: begin
                    case (funct)
                        FN_ADD: begin reg_write <= 1'b1; alu_op <= ALU_ADD; end
                        FN_SUB: begin reg_write <= 1'b1; alu_op <= ALU_SUB; end
                        FN_AND: begin reg_write <= 1'b1; alu_op <= ALU_AND; end
                        FN_OR:  begin reg_write <= 1'b1; alu_op <= ALU_OR;  end
                        FN_SLT: begin reg_write <= 1'b1; alu_op <= ALU_SLT; end
                        FN_MUL: begin reg_write <= 1'b1; alu_op <= ALU_MUL; end
                        default: ; // Unknown function stays a bubble
                    endcase
                end
                OP_ADDI: begin
                    reg_write <= 1'b1;
                    alu_src   <= 1'b1;
                    alu_op    <= ALU_ADD;
                end
                OP_ORI: begin
                    reg_write <= 1'b1;
                    alu_src   <= 1'b1;
                    alu_op    <= ALU_OR;
                end
                OP_LDW, OP_LDB: begin
                    reg_write  <= 1'b1;
                    mem_to_reg <= 1'b1;
                    mem_read   <= 1'b1;
                    alu_src    <= 1'b1;
                    byte_word  <= (opcode == OP_LDW);
                end
                OP_STW, OP_STB: begin
                    mem_write <= 1'b1;
                    alu_op    <= ALU_PASS_B; // Store data through ALU, address on own adder
                    byte_word <= (opcode == OP_STW);
                end
                OP_BEQ: begin
                    branch <= 1'b1;
                    alu_op <= ALU_SUB;
                end
                default: ; // J resolved in decode, nothing to carry
            endcase
        end
    end

endmodule

/* hdl/register_file.sv */
`include "cpu_config.svh"

module register_file import pipe_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rd_addr_a,
    input  reg_addr_t rd_addr_b,
    output word_t     rd_data_a,
    output word_t     rd_data_b,
    input  logic      wr_en,
    input  reg_addr_t wr_addr,
    input  word_t     wr_data
);

    word_t regs [`NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin // r0 never written
            regs[wr_addr] <= wr_data;
        end
    end

    // Write-first, a read of the register being written sees the new value
    assign rd_data_a = (rd_addr_a == '0) ? '0 :
                       (wr_en && (wr_addr == rd_addr_a)) ? wr_data : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 :
                       (wr_en && (wr_addr == rd_addr_b)) ? wr_data : regs[rd_addr_b];

endmodule

/* hdl/decode_stage.sv */
`include "cpu_config.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  logic                stall,
    input  word_t               pc,
    input  logic [`INSTR_W-1:0] instruction,
    output logic                jump_taken,
    output word_t               jump_target,
    output reg_addr_t           rd_addr_a,
    output reg_addr_t           rd_addr_b,
    input  word_t               rd_data_a,
    input  word_t               rd_data_b,
    decode_exec_if.source       dx
);

    opcode_t     opcode;
    funct_t      funct;
    reg_addr_t   rt_field;
    reg_addr_t   rd_field;
    imm16_t      imm16;
    jump_index_t jump_index;
    word_t       imm_ext;
    reg_addr_t   dest_sel;
    logic        accept;

    // Field split
    assign opcode     = opcode_t'(instruction[31:26]);
    assign funct      = funct_t'(instruction[5:0]);
    assign rt_field   = instruction[20:16];
    assign rd_field   = instruction[15:11];
    assign imm16      = instruction[15:0];
    assign jump_index = instruction[25:0];

    assign accept = instr_valid && !stall; // Instruction moves into decode register

    // Register file read addresses straight from the instruction
    assign rd_addr_a = instruction[25:21]; // rs
    assign rd_addr_b = rt_field;

    // Jump resolves here, fetch redirects in the same cycle
    assign jump_taken  = accept && (opcode == OP_J);
    assign jump_target = {pc[`DATA_W-1:`DATA_W-4], jump_index, 2'b00};

    // ORI is the only zero-extended immediate
    assign imm_ext = (opcode == OP_ORI) ? {{(`DATA_W-16){1'b0}}, imm16}
                                        : {{(`DATA_W-16){imm16[15]}}, imm16};

    // R-type writes rd, I-type writes rt
    assign dest_sel = (opcode == OP_RTYPE) ? rd_field : rt_field;

    always_ff @(posedge clk) begin
        if (reset) begin
            dx.ex_valid <= 1'b0;
        end else begin
            dx.ex_valid <= accept; // Stall loads a bubble
        end
    end

    // Payload, only meaningful while ex_valid is high
    always_ff @(posedge clk) begin
        if (accept) begin
            dx.pc        <= pc;
            dx.operand_a <= rd_data_a;
            dx.operand_b <= rd_data_b;
            dx.imm       <= imm_ext;
            dx.dest_reg  <= dest_sel;
        end
    end

    // Control strobes registered in step with the payload
    control_unit u_control (
        .clk        (clk),
        .reset      (reset),
        .stall      (!accept), // Stall or empty slot gives a bubble
        .opcode     (opcode),
        .funct      (funct),
        .reg_write  (dx.reg_write),
        .mem_to_reg (dx.mem_to_reg),
        .mem_write  (dx.mem_write),
        .mem_read   (dx.mem_read),
        .byte_word  (dx.byte_word),
        .branch     (dx.branch),
        .alu_src    (dx.alu_src),
        .alu_op     (dx.alu_op)
    );

endmodule

/* hdl/execute_stage.sv */
module execute_stage import pipe_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    decode_exec_if.sink   dx,
    exec_result_if.source xr,
    output logic          mem_read,
    output logic          mem_write,
    output logic          mem_byte,  // Byte access when high
    output word_t         mem_addr,
    output word_t         mem_wdata,
    output logic          branch_taken,
    output word_t         branch_target
);

    word_t alu_b;
    word_t alu_out;
    word_t addr;
    word_t store_data;
    logic  operands_equal;

    assign alu_b = dx.alu_src ? dx.imm : dx.operand_b;

    always_comb begin
        case (dx.alu_op)
            ALU_ADD:    alu_out = dx.operand_a + alu_b;
            ALU_SUB:    alu_out = dx.operand_a - alu_b;
            ALU_AND:    alu_out = dx.operand_a & alu_b;
            ALU_OR:     alu_out = dx.operand_a | alu_b;
            ALU_SLT:    alu_out = word_t'($signed(dx.operand_a) < $signed(alu_b));
            ALU_MUL:    alu_out = dx.operand_a * alu_b; // Truncated to low word
            ALU_PASS_B: alu_out = alu_b;
            default:    alu_out = '0;
        endcase
    end

    // Separate address adder, base plus offset
    assign addr = dx.operand_a + dx.imm;

    // STB puts only the low byte on the bus
    assign store_data = dx.byte_word ? alu_out : word_t'(alu_out[7:0]);

    assign operands_equal = (dx.operand_a == dx.operand_b);

    // Strobes, cleared by reset
    always_ff @(posedge clk) begin
        if (reset) begin
            xr.wb_pending <= 1'b0;
            mem_read      <= 1'b0;
            mem_write     <= 1'b0;
            mem_byte      <= 1'b0;
            branch_taken  <= 1'b0;
        end else begin
            xr.wb_pending <= dx.ex_valid && dx.reg_write;
            mem_read      <= dx.ex_valid && dx.mem_read;
            mem_write     <= dx.ex_valid && dx.mem_write;
            mem_byte      <= dx.ex_valid && (dx.mem_read || dx.mem_write) && !dx.byte_word;
            branch_taken  <= dx.ex_valid && dx.branch && operands_equal;
        end
    end

    // Payload
    always_ff @(posedge clk) begin
        xr.dest_reg    <= dx.dest_reg;
        xr.alu_result  <= alu_out;
        xr.mem_to_reg  <= dx.mem_to_reg;
        xr.byte_word   <= dx.byte_word;
        xr.load_offset <= addr[1:0];
        mem_addr       <= addr;
        mem_wdata      <= store_data;
        branch_target  <= dx.pc + word_t'(4) + (dx.imm << 2); // pc+4 plus word offset
    end

endmodule

/* hdl/result_stage.sv */
`include "cpu_config.svh"

module result_stage import pipe_pkg::*; (
    exec_result_if.sink xr,
    input  word_t       mem_rdata,   // Answered in the same cycle as the request
    output logic        wr_en,
    output reg_addr_t   wr_addr,
    output word_t       wr_data
);

    logic [7:0] load_byte;
    word_t      load_data;

    // Little-endian byte lane pick
    assign load_byte = mem_rdata[8*xr.load_offset +: 8];

    // LDW full word, LDB zero-extended byte
    assign load_data = xr.byte_word ? mem_rdata
                                    : {{(`DATA_W-8){1'b0}}, load_byte};

    assign wr_data = xr.mem_to_reg ? load_data : xr.alu_result;
    assign wr_addr = xr.dest_reg;
    assign wr_en   = xr.wb_pending && (xr.dest_reg != '0); // Drop writes to r0

endmodule

/* hdl/pipeline_top.sv */
`include "cpu_config.svh"

module pipeline_top import pipe_pkg::*; (
    input  logic                clk,
    input  logic                reset,
    input  logic                instr_valid,
    input  logic                stall,
    input  word_t               pc,
    input  logic [`INSTR_W-1:0] instruction,
    input  word_t               mem_rdata,
    output logic                jump_taken,    // Combinational, same cycle
    output word_t               jump_target,
    output logic                branch_taken,  // One cycle after acceptance
    output word_t               branch_target,
    output logic                mem_read,
    output logic                mem_write,
    output logic                mem_byte,
    output word_t               mem_addr,
    output word_t               mem_wdata,
    output logic                wb_valid,
    output reg_addr_t           wb_reg,
    output word_t               wb_data
);

    reg_addr_t rd_addr_a;
    reg_addr_t rd_addr_b;
    word_t     rd_data_a;
    word_t     rd_data_b;

    decode_exec_if dx_if ();
    exec_result_if xr_if ();

    decode_stage u_decode (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .stall       (stall),
        .pc          (pc),
        .instruction (instruction),
        .jump_taken  (jump_taken),
        .jump_target (jump_target),
        .rd_addr_a   (rd_addr_a),
        .rd_addr_b   (rd_addr_b),
        .rd_data_a   (rd_data_a),
        .rd_data_b   (rd_data_b),
        .dx          (dx_if)
    );

    // Write port fed by the result stage, report mirrors it
    register_file u_regs (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_a (rd_addr_a),
        .rd_addr_b (rd_addr_b),
        .rd_data_a (rd_data_a),
        .rd_data_b (rd_data_b),
        .wr_en     (wb_valid),
        .wr_addr   (wb_reg),
        .wr_data   (wb_data)
    );

    execute_stage u_execute (
        .clk           (clk),
        .reset         (reset),
        .dx            (dx_if),
        .xr            (xr_if),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .mem_byte      (mem_byte),
        .mem_addr      (mem_addr),
        .mem_wdata     (mem_wdata),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    result_stage u_result (
        .xr        (xr_if),
        .mem_rdata (mem_rdata),
        .wr_en     (wb_valid),
        .wr_addr   (wb_reg),
        .wr_data   (wb_data)
    );

endmodule

/* bench/pipeline_assertions.sv */
`include "cpu_config.svh"

// Reference model of the pipeline, checked at the top-level ports
module pipeline_assertions import isa_pkg::*, pipe_pkg::*; (
    input logic                clk,
    input logic                reset,
    input logic                instr_valid,
    input logic                stall,
    input word_t               pc,
    input logic [`INSTR_W-1:0] instruction,
    input logic                jump_taken,
    input word_t               jump_target,
    input logic                branch_taken,
    input word_t               branch_target,
    input logic                mem_read,
    input logic                mem_write,
    input logic                mem_byte,
    input word_t               mem_addr,
    input word_t               mem_wdata,
    input logic                wb_valid,
    input reg_addr_t           wb_reg,
    input word_t               wb_data
);

    // What one instruction should show on the ports
    typedef struct packed {
        word_t     pc;
        logic      wb;
        reg_addr_t wb_reg;
        word_t     wb_data;
        logic      mem_rd;
        logic      mem_wr;
        logic      mem_byte;
        word_t     mem_addr;
        word_t     mem_wdata;
        logic      br;
        word_t     br_target;
    } expect_t;

    bit        failed = 1'b0;  // Polled by the testbench
    word_t     model_regs [`NUM_REGS];
    word_t     model_mem [256];
    expect_t   nx;
    expect_t   s1;             // Held while the instruction sits in execute
    expect_t   s2;             // Held while its results are on the ports
    opcode_t   op;
    funct_t    fn;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    word_t     a_val;
    word_t     b_val;
    word_t     simm;
    word_t     ea;
    word_t     mem_word;
    word_t     store_word;
    logic      accepted;
    logic      exp_jump;
    word_t     exp_jump_target;

    assign op       = opcode_t'(instruction[31:26]);
    assign fn       = funct_t'(instruction[5:0]);
    assign rs       = instruction[25:21];
    assign rt       = instruction[20:16];
    assign rd       = instruction[15:11];
    assign a_val    = model_regs[rs];
    assign b_val    = model_regs[rt];
    assign simm     = {{16{instruction[15]}}, instruction[15:0]};
    assign ea       = a_val + simm;       // Base plus signed offset
    assign mem_word = model_mem[ea[9:2]];
    assign accepted = instr_valid && !stall;

    // Jump goes out in the same cycle, 256 MB region of the PC
    assign exp_jump        = accepted && (op == OP_J);
    assign exp_jump_target = {pc[31:28], instruction[25:0], 2'b00};

    always_comb begin
        nx         = '0;
        nx.pc      = pc;
        store_word = mem_word;
        case (op)
            OP_RTYPE: begin
                nx.wb     = (rd != '0);   // r0 never reported
                nx.wb_reg = rd;
                case (fn)
                    FN_ADD:  nx.wb_data = a_val + b_val;
                    FN_SUB:  nx.wb_data = a_val - b_val;
                    FN_AND:  nx.wb_data = a_val & b_val;
                    FN_OR:   nx.wb_data = a_val | b_val;
                    FN_SLT:  nx.wb_data = ($signed(a_val) < $signed(b_val)) ? 32'd1 : 32'd0;
                    FN_MUL:  nx.wb_data = a_val * b_val;
                    default: nx.wb = 1'b0;
                endcase
            end
            OP_ADDI, OP_ORI: begin
                nx.wb      = (rt != '0);
                nx.wb_reg  = rt;
                nx.wb_data = (op == OP_ORI) ? (a_val | {16'h0, instruction[15:0]})
                                            : (a_val + simm);
            end
            OP_LDW, OP_LDB: begin
                nx.mem_rd   = 1'b1;
                nx.mem_byte = (op == OP_LDB);
                nx.mem_addr = ea;
                nx.wb       = (rt != '0);
                nx.wb_reg   = rt;
                nx.wb_data  = (op == OP_LDB) ? ((mem_word >> (8 * ea[1:0])) & 32'hff)
                                             : mem_word;
            end
            OP_STW, OP_STB: begin
                nx.mem_wr    = 1'b1;
                nx.mem_byte  = (op == OP_STB);
                nx.mem_addr  = ea;
                nx.mem_wdata = (op == OP_STB) ? {24'h0, b_val[7:0]} : b_val;
                if (op == OP_STB) begin
                    store_word[8 * ea[1:0] +: 8] = b_val[7:0]; // Other lanes kept
                end else begin
                    store_word = b_val;
                end
            end
            OP_BEQ: begin
                nx.br        = (a_val == b_val);
                nx.br_target = pc + 32'd4 + (simm << 2);
            end
            default: ;
        endcase
    end

    // Model state moves only on accepted instructions
    always @(posedge clk) begin
        if (reset) begin
            s1 <= '0;
            s2 <= '0;
            for (int i = 0; i < `NUM_REGS; i++) begin
                model_regs[i] <= '0;
            end
            for (int i = 0; i < 256; i++) begin
                model_mem[i] <= '0;
            end
        end else begin
            s2 <= s1;
            s1 <= accepted ? nx : '0;  // Stalled slot shows nothing
            if (accepted && nx.wb) begin
                model_regs[nx.wb_reg] <= nx.wb_data;
            end
            if (accepted && nx.mem_wr) begin
                model_mem[ea[9:2]] <= store_word;
            end
        end
    end

    a_wb: assert property (@(posedge clk) disable iff (reset)
        wb_valid == s2.wb && (!s2.wb || (wb_reg == s2.wb_reg && wb_data == s2.wb_data)))
    else begin
        failed = 1'b1;
        $error("[ERROR] write-back at pc %h: expected %b r%0d %h, actual %b r%0d %h",
               s2.pc, s2.wb, s2.wb_reg, s2.wb_data, wb_valid, wb_reg, wb_data);
    end

    a_mem: assert property (@(posedge clk) disable iff (reset)
        mem_read == s2.mem_rd && mem_write == s2.mem_wr
        && (!(s2.mem_rd || s2.mem_wr) || (mem_byte == s2.mem_byte && mem_addr == s2.mem_addr))
        && (!s2.mem_wr || mem_wdata == s2.mem_wdata))
    else begin
        failed = 1'b1;
        $error("[ERROR] memory at pc %h: expected %b%b%b %h %h, actual %b%b%b %h %h",
               s2.pc, s2.mem_rd, s2.mem_wr, s2.mem_byte, s2.mem_addr, s2.mem_wdata,
               mem_read, mem_write, mem_byte, mem_addr, mem_wdata);
    end

    a_branch: assert property (@(posedge clk) disable iff (reset)
        branch_taken == s2.br && (!s2.br || branch_target == s2.br_target))
    else begin
        failed = 1'b1;
        $error("[ERROR] branch at pc %h: expected %b %h, actual %b %h",
               s2.pc, s2.br, s2.br_target, branch_taken, branch_target);
    end

    a_jump: assert property (@(posedge clk) disable iff (reset)
        jump_taken == exp_jump && (!exp_jump || jump_target == exp_jump_target))
    else begin
        failed = 1'b1;
        $error("[ERROR] jump at pc %h: expected %b %h, actual %b %h",
               pc, exp_jump, exp_jump_target, jump_taken, jump_target);
    end

endmodule

bind pipeline_top pipeline_assertions u_checks (.*);

/* bench/pipeline_tb.sv */
module pipeline_tb import isa_pkg::*, pipe_pkg::*;;

    logic        clk = 1'b0;
    logic        reset;
    logic        instr_valid;
    logic        stall;
    word_t       pc;
    logic [31:0] instruction;
    word_t       mem_rdata;
    logic        jump_taken;
    word_t       jump_target;
    logic        branch_taken;
    word_t       branch_target;
    logic        mem_read;
    logic        mem_write;
    logic        mem_byte;
    word_t       mem_addr;
    word_t       mem_wdata;
    logic        wb_valid;
    reg_addr_t   wb_reg;
    word_t       wb_data;
    word_t       mem [256];    // Data memory, word indexed
    logic [31:0] rng_state;

    always #4 clk = ~clk;

    pipeline_top u_dut (.*);

    // Loads answered in the request cycle
    assign mem_rdata = mem[mem_addr[9:2]];

    always @(posedge clk) begin
        if (mem_write) begin
            if (mem_byte) begin
                mem[mem_addr[9:2]][8 * mem_addr[1:0] +: 8] <= mem_wdata[7:0];
            end else begin
                mem[mem_addr[9:2]] <= mem_wdata;
            end
        end
    end

    // LCG, upper bits as a 16-bit immediate
    function automatic logic [15:0] random_imm();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state[30:15];
    endfunction

    function automatic logic [31:0] r_type(funct_t fn, reg_addr_t rd, reg_addr_t rs,
                                           reg_addr_t rt);
        return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] i_type(opcode_t op, reg_addr_t rt, reg_addr_t rs,
                                           logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Present one instruction, stalled first if asked, then two idle cycles
    task automatic issue(input logic [31:0] instr, input int stall_cycles);
        instruction = instr;
        instr_valid = 1'b1;
        stall       = 1'b1;
        repeat (stall_cycles) @(negedge clk); // Held while back-pressured
        stall = 1'b0;
        @(negedge clk);
        instr_valid = 1'b0;
        instruction = '0;
        repeat (2) @(negedge clk);
        pc = pc + 32'd4;
    endtask

    // Wait for three quiet cycles on the result ports
    task automatic drain();
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < 3) begin
            @(negedge clk);
            cycles++;
            quiet = (wb_valid || mem_read || mem_write || branch_taken) ? 0 : quiet + 1;
            if (cycles > 20) begin
                $display("Errors found");
                $fatal(1, "pipeline outputs did not go idle after the program");
            end
        end
    endtask

    // First failed assertion ends the run
    always @(negedge clk) begin
        if (u_dut.u_checks.failed) begin
            $display("Errors found");
            $fatal(1, "assertion failure in the pipeline checks");
        end
    end

    initial begin
        #20000;
        $display("Errors found");
        $fatal(1, "simulation ran past its time limit");
    end

    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = '0;
        end
        rng_state   = 32'd30;
        reset       = 1'b1;
        instr_valid = 1'b0;
        stall       = 1'b0;
        pc          = 32'h9000_1000;   // Upper nibble shows in jump targets
        instruction = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (3) @(negedge clk);     // Idle ports after reset

        // Random operands
        issue(i_type(OP_ADDI, 5'd1, 5'd0, random_imm()), 0);
        issue(i_type(OP_ORI, 5'd2, 5'd0, random_imm()), 0);
        issue(i_type(OP_ADDI, 5'd3, 5'd0, random_imm() | 16'h8000), 0); // Negative
        issue(i_type(OP_ORI, 5'd4, 5'd0, random_imm() | 16'h8000), 0);  // No sign fill
        issue(i_type(OP_ORI, 5'd4, 5'd4, random_imm()), 0);

        // ALU operations
        issue(r_type(FN_ADD, 5'd5, 5'd1, 5'd2), 0);
        issue(r_type(FN_SUB, 5'd6, 5'd1, 5'd3), 0);
        issue(r_type(FN_AND, 5'd7, 5'd2, 5'd4), 0);
        issue(r_type(FN_OR, 5'd8, 5'd1, 5'd4), 0);
        issue(r_type(FN_SLT, 5'd9, 5'd3, 5'd1), 0);
        issue(r_type(FN_SLT, 5'd10, 5'd1, 5'd3), 0);
        issue(r_type(FN_MUL, 5'd11, 5'd1, 5'd2), 0);
        issue(r_type(FN_MUL, 5'd17, 5'd3, 5'd4), 0);
        issue(r_type(FN_ADD, 5'd0, 5'd1, 5'd2), 0);   // r0 target, no write-back

        // Stores then loads around base 64
        issue(i_type(OP_ADDI, 5'd12, 5'd0, 16'd64), 0);
        issue(i_type(OP_STW, 5'd1, 5'd12, 16'd0), 0);
        issue(i_type(OP_STB, 5'd2, 5'd12, 16'd1), 0);
        issue(i_type(OP_STW, 5'd3, 5'd12, 16'hfffc), 0); // Negative offset
        issue(i_type(OP_LDW, 5'd13, 5'd12, 16'd0), 0);
        issue(i_type(OP_LDB, 5'd14, 5'd12, 16'd1), 0);
        issue(i_type(OP_LDB, 5'd15, 5'd12, 16'd3), 0);
        issue(i_type(OP_LDW, 5'd16, 5'd12, 16'hfffc), 0);

        // Control flow
        issue(i_type(OP_BEQ, 5'd1, 5'd1, 16'd3), 0);     // Taken
        issue(i_type(OP_BEQ, 5'd2, 5'd1, 16'hfffe), 0);  // Operands differ
        issue({OP_J, 10'd0, random_imm()}, 0);

        // Back-pressure, each held then accepted once
        issue(i_type(OP_STW, 5'd5, 5'd12, 16'd8), 2);
        issue(r_type(FN_SUB, 5'd18, 5'd5, 5'd6), 1);
        issue(i_type(OP_LDW, 5'd19, 5'd12, 16'd8), 1);
        issue({OP_J, 10'd0, random_imm()}, 2);

        drain();
        if (u_dut.u_checks.failed) begin
            $display("Errors found");
            $fatal(1, "assertion failure in the pipeline checks");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* filelist.f */
+incdir+hdl
hdl/pipe_pkg.sv
hdl/isa_pkg.sv
hdl/stage_if.sv
hdl/control_unit.sv
hdl/register_file.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/result_stage.sv
hdl/pipeline_top.sv
bench/pipeline_assertions.sv
bench/pipeline_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := pipeline_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --assert --timing -Mdir $(OBJ_DIR) --top-module $(TOP)
RUN_FLAGS := +verilator+error+limit+100

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS)

clean:
	rm -rf $(OBJ_DIR)
